// File: epu_pkg.sv
package epu_pkg;

    // pixel coordinates and frame geometry.
    localparam int POS_W  = 11;
    localparam int DIM_W  = 12;
    localparam int FNUM_W = 9;

    // cavlc code word as delivered by the entropy coder.
    localparam int CODE_W = 128;
    localparam int BITS_W = 7;

    // bit accumulator in the packer.
    localparam int ACC_W     = 256;
    localparam int ACC_LEN_W = 9;

    // output word buffer.
    localparam int BUF_WORDS = 64;
    localparam int ADDR_W    = 6;
    localparam int CNT_W     = 7; // holds 0 to 64.

    // the slice header is split around the frame number field.
    localparam int SLICE_HDR_LEN = 75;
    localparam logic [48:0] SLICE_HDR_HI = {32'd1, 17'b01100101100010001};
    localparam logic [16:0] SLICE_HDR_LO = 17'b10000000000001111;

    // fixed macroblock header for i16x16 prediction with no residual flags.
    localparam int MB_HDR_LEN = 22;
    localparam logic [MB_HDR_LEN-1:0] MB_HDR = 22'b1111111111111111110111;

    typedef struct packed {
        logic [CODE_W-1:0] code; // right aligned, zero above the valid bits.
        logic [BITS_W-1:0] bits;
    } cavlc_blk_t;

    typedef struct packed {
        logic [POS_W-1:0] x;
        logic [POS_W-1:0] y;
    } blk_pos_t;

    typedef struct packed {
        logic [DIM_W-1:0]  width;  // multiple of 16.
        logic [DIM_W-1:0]  height; // multiple of 16.
        logic [FNUM_W-1:0] frame_num;
    } frame_cfg_t;

    typedef struct packed {
        logic slice_start;
        logic mb_start;
        logic last_blk;
    } blk_kind_t;

endpackage

// File: blk_scan.sv
`timescale 1ns/1ps

module blk_scan (
    input  logic                clk,
    input  logic                rst,
    input  logic                frame_reset,
    input  epu_pkg::frame_cfg_t cfg,
    input  logic                blk_valid,
    output epu_pkg::blk_kind_t  kind
);

    import epu_pkg::*;

    logic [POS_W-1:0] mb_x;
    logic [POS_W-1:0] mb_y;
    logic [1:0]       sub_x; // 4x4 column inside the macroblock.
    logic [1:0]       sub_y; // 4x4 row inside the macroblock.
    blk_pos_t         pos;
    logic             mb_last_col;
    logic             mb_last_row;

    assign pos.x = mb_x + POS_W'({sub_x, 2'b00});
    assign pos.y = mb_y + POS_W'({sub_y, 2'b00});

    assign mb_last_col = (DIM_W'(mb_x) + DIM_W'(16)) == cfg.width;
    assign mb_last_row = (DIM_W'(mb_y) + DIM_W'(16)) == cfg.height;

    always_comb begin
        kind.slice_start = (pos.x == '0) && (pos.y == '0);
        kind.mb_start    = (sub_x == 2'd0) && (sub_y == 2'd0);
        kind.last_blk    = (DIM_W'(pos.x) == cfg.width - DIM_W'(4)) &&
                           (DIM_W'(pos.y) == cfg.height - DIM_W'(4));
    end

    always_ff @(posedge clk) begin
        if (rst || frame_reset) begin
            mb_x  <= '0;
            mb_y  <= '0;
            sub_x <= '0;
            sub_y <= '0;
        end else if (blk_valid) begin
            sub_x <= sub_x + 2'd1; // wraps to 0 after the fourth column.
            if (sub_x == 2'd3) begin
                sub_y <= sub_y + 2'd1;
                if (sub_y == 2'd3) begin
                    // the sixteenth block is done so step to the next macroblock.
                    if (mb_last_col) begin
                        mb_x <= '0;
                        mb_y <= mb_last_row ? '0 : mb_y + POS_W'(16);
                    end else begin
                        mb_x <= mb_x + POS_W'(16);
                    end
                end
            end
        end
    end

endmodule

// File: bit_packer.sv
`timescale 1ns/1ps

module bit_packer (
    input  logic                clk,
    input  logic                rst,
    input  logic                frame_reset,
    input  epu_pkg::frame_cfg_t cfg,
    input  logic                blk_valid,
    input  epu_pkg::cavlc_blk_t blk,
    input  epu_pkg::blk_kind_t  kind,
    output logic                word_valid,
    output logic [31:0]         word
);

    import epu_pkg::*;

    logic [ACC_W-1:0]         acc;     // newest bit at position 0.
    logic [ACC_LEN_W-1:0]     acc_len;
    logic [4:0]               frame_mod; // frame bit count modulo 32.
    logic [ACC_W-1:0]         acc_out;
    logic [ACC_W-1:0]         nxt_acc;
    logic [ACC_LEN_W-1:0]     nxt_len;
    logic [ACC_LEN_W-1:0]     left_len;
    logic [ACC_LEN_W-1:0]     added;
    logic [4:0]               nxt_mod;
    logic [4:0]               pad_len;
    logic [SLICE_HDR_LEN-1:0] slice_hdr;

    assign slice_hdr = {SLICE_HDR_HI, cfg.frame_num, SLICE_HDR_LO};

    // the oldest 32 bits sit just below the fill count.
    assign word_valid = acc_len >= ACC_LEN_W'(32);
    assign acc_out    = acc >> (acc_len - ACC_LEN_W'(32));
    assign word       = acc_out[31:0];

    assign left_len = word_valid ? acc_len - ACC_LEN_W'(32) : acc_len;

    always_comb begin
        nxt_acc = acc;
        added   = '0;
        pad_len = '0;

        if (blk_valid) begin
            if (kind.slice_start) begin
                nxt_acc = (nxt_acc << SLICE_HDR_LEN) | ACC_W'(slice_hdr);
                added   = added + ACC_LEN_W'(SLICE_HDR_LEN);
            end

            if (kind.mb_start) begin
                nxt_acc = (nxt_acc << MB_HDR_LEN) | ACC_W'(MB_HDR);
                added   = added + ACC_LEN_W'(MB_HDR_LEN);
            end

            nxt_acc = (nxt_acc << blk.bits) | ACC_W'(blk.code);
            added   = added + ACC_LEN_W'(blk.bits);

            if (kind.last_blk) begin
                // stop bit, then zeros to the next 32-bit frame boundary.
                nxt_acc = (nxt_acc << 1) | ACC_W'(1);
                added   = added + ACC_LEN_W'(1);
                pad_len = 5'd0 - (frame_mod + added[4:0]);
                nxt_acc = nxt_acc << pad_len;
                added   = added + ACC_LEN_W'(pad_len);
            end
        end

        nxt_len = left_len + added;
        nxt_mod = frame_mod + added[4:0];
    end

    always_ff @(posedge clk) begin
        acc <= nxt_acc;
    end

    always_ff @(posedge clk) begin
        if (rst || frame_reset) begin
            acc_len   <= '0;
            frame_mod <= '0;
        end else begin
            acc_len   <= nxt_len;
            frame_mod <= nxt_mod;
        end
    end

endmodule

// File: stream_buf.sv
`timescale 1ns/1ps

module stream_buf (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       buf_clear,
    input  logic                       word_valid,
    input  logic [31:0]                word,
    input  logic [epu_pkg::ADDR_W-1:0] rd_addr,
    output logic [31:0]                rd_data,
    output logic [epu_pkg::CNT_W-1:0]  word_cnt
);

    import epu_pkg::*;

    logic [31:0] mem [BUF_WORDS];
    logic        full;

    assign full    = word_cnt == CNT_W'(BUF_WORDS);
    assign rd_data = mem[rd_addr];

    always_ff @(posedge clk) begin
        if (buf_clear) begin
            for (int i = 0; i < BUF_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (word_valid && !full) begin
            mem[word_cnt[ADDR_W-1:0]] <= word;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || buf_clear) begin
            word_cnt <= '0;
        end else if (word_valid && !full) begin
            word_cnt <= word_cnt + CNT_W'(1); // words past 64 are dropped.
        end
    end

endmodule

// File: epu_h264_top.sv
`timescale 1ns/1ps

module epu_h264_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       frame_reset,
    input  logic                       buf_clear,
    input  epu_pkg::frame_cfg_t        cfg,
    input  logic                       blk_valid,
    input  epu_pkg::cavlc_blk_t        blk,
    input  logic [epu_pkg::ADDR_W-1:0] rd_addr,
    output logic [31:0]                rd_data,
    output logic [epu_pkg::CNT_W-1:0]  word_cnt,
    output logic                       frame_done
);

    import epu_pkg::*;

    blk_kind_t   kind;
    logic        word_valid;
    logic [31:0] word;

    blk_scan u_blk_scan (
        .clk         (clk),
        .rst         (rst),
        .frame_reset (frame_reset),
        .cfg         (cfg),
        .blk_valid   (blk_valid),
        .kind        (kind)
    );

    bit_packer u_bit_packer (
        .clk         (clk),
        .rst         (rst),
        .frame_reset (frame_reset),
        .cfg         (cfg),
        .blk_valid   (blk_valid),
        .blk         (blk),
        .kind        (kind),
        .word_valid  (word_valid),
        .word        (word)
    );

    stream_buf u_stream_buf (
        .clk        (clk),
        .rst        (rst),
        .buf_clear  (buf_clear),
        .word_valid (word_valid),
        .word       (word),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .word_cnt   (word_cnt)
    );

    always_ff @(posedge clk) begin
        if (rst || frame_reset) begin
            frame_done <= 1'b0;
        end else if (blk_valid && kind.last_blk) begin
            frame_done <= 1'b1; // held until the next frame starts.
        end
    end

endmodule

// File: tb_epu_h264.sv
`timescale 1ns/1ps

module tb_epu_h264;

    import epu_pkg::*;

    localparam int TEST_CYCLES = 1400; // upper bound on all six tests with their buffer reads.
    localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

    logic              clk;
    logic              rst;
    logic              frame_reset;
    logic              buf_clear;
    frame_cfg_t        cfg;
    logic              blk_valid;
    cavlc_blk_t        blk;
    logic [ADDR_W-1:0] rd_addr;
    logic [31:0]       rd_data;
    logic [CNT_W-1:0]  word_cnt;
    logic              frame_done;

    logic [31:0] rand_state;
    int          value_errs;
    int          other_errs;
    int          cycles;

    // reference model of the bit stream and the buffer.
    bit          bit_q[$];
    logic [31:0] exp_mem [BUF_WORDS];
    int          exp_cnt;
    int          words_made; // counts the words the buffer drops too.
    int          frame_bits;
    int          last_pad;

    epu_h264_top u_epu_h264_top (
        .clk         (clk),
        .rst         (rst),
        .frame_reset (frame_reset),
        .buf_clear   (buf_clear),
        .cfg         (cfg),
        .blk_valid   (blk_valid),
        .blk         (blk),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .word_cnt    (word_cnt),
        .frame_done  (frame_done)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run stopped after %0d cycles without finishing", cycles);
            $display("errors: %0d value, %0d other", value_errs, other_errs);
            $display("tests failed");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_true(input logic ok, input string what);
        assert (ok) else begin
            $display("%0t: %s", $time, what);
            other_errs++;
        end
    endtask

    // appends n bits, msb first, and cuts full words off the front.
    task automatic push_bits(input logic [127:0] v, input int n);
        logic [31:0] w;
        for (int k = n - 1; k >= 0; k--) begin
            bit_q.push_back(v[k]);
        end
        frame_bits += n;
        while (bit_q.size() >= 32) begin
            for (int k = 31; k >= 0; k--) begin
                w[k] = bit_q.pop_front();
            end
            words_made++;
            if (exp_cnt < BUF_WORDS) begin
                exp_mem[exp_cnt] = w;
                exp_cnt++;
            end
        end
    endtask

    // sends block idx of the current frame and mirrors it in the model.
    task automatic send_block(input int idx, input int max_bits);
        int           mbs_per_row;
        int           mb;
        int           sub;
        int           x;
        int           y;
        int           n;
        int           start_bits;
        int           idle;
        logic         last;
        logic [127:0] code;
        mbs_per_row = cfg.width / 16;
        mb          = idx / 16;
        sub         = idx % 16;
        x           = (mb % mbs_per_row) * 16 + (sub % 4) * 4;
        y           = (mb / mbs_per_row) * 16 + (sub / 4) * 4;
        last        = (x == cfg.width - 4) && (y == cfg.height - 4);
        n           = 1 + (next_rand() >> 16) % max_bits;
        code        = {next_rand(), next_rand(), next_rand(), next_rand()};
        code        = code & ((128'd1 << n) - 128'd1);
        start_bits  = frame_bits;
        if (x == 0 && y == 0) begin
            push_bits(128'(SLICE_HDR_HI), 49);
            push_bits(128'(cfg.frame_num), FNUM_W);
            push_bits(128'(SLICE_HDR_LO), 17);
        end
        if (sub == 0) begin
            push_bits(128'(MB_HDR), MB_HDR_LEN);
        end
        push_bits(code, n);
        if (last) begin
            push_bits(128'd1, 1);
            last_pad = (32 - frame_bits % 32) % 32;
            push_bits(128'd0, last_pad);
        end
        idle = (frame_bits - start_bits + 31) / 32 + 1; // one idle cycle per 32 bits sent.
        @(posedge clk);
        #10;
        blk_valid = 1'b1;
        blk.code  = code;
        blk.bits  = BITS_W'(n);
        @(posedge clk);
        #10;
        blk_valid = 1'b0;
        blk       = '0;
        check_value("frame_done", 32'(frame_done), 32'(last)); // rises on the last block.
        repeat (idle) @(posedge clk);
        #10;
    endtask

    task automatic restart_frame(input int width, input int height, input int fnum);
        @(posedge clk);
        #10;
        cfg.width     = DIM_W'(width);
        cfg.height    = DIM_W'(height);
        cfg.frame_num = FNUM_W'(fnum);
        frame_reset   = 1'b1;
        @(posedge clk);
        #10;
        frame_reset = 1'b0;
        bit_q.delete(); // bits still in the accumulator are dropped.
        frame_bits = 0;
    endtask

    task automatic clear_buffer();
        @(posedge clk);
        #10;
        buf_clear = 1'b1;
        @(posedge clk);
        #10;
        buf_clear = 1'b0;
        exp_cnt   = 0;
        for (int a = 0; a < BUF_WORDS; a++) begin
            exp_mem[a] = '0;
        end
    endtask

    task automatic read_word(input int addr, output logic [31:0] data);
        @(posedge clk);
        #10;
        rd_addr = ADDR_W'(addr);
        #40;
        data = rd_data;
    endtask

    task automatic check_buffer();
        logic [31:0] got;
        check_value("word_cnt", 32'(word_cnt), exp_cnt);
        for (int a = 0; a < BUF_WORDS; a++) begin
            read_word(a, got);
            check_value($sformatf("rd_data[%0d]", a), got, exp_mem[a]);
        end
    endtask

    task automatic check_slice_hdr(input int start, input int fnum);
        logic [31:0] got;
        read_word(start, got);
        check_value("slice header word", got, SLICE_HDR_HI[48:17]);
        read_word(start + 1, got);
        // the frame number starts 49 bits into the header, at bit 14 of the second word.
        check_value("frame_num field", 32'(got[14:6]), fnum);
    endtask

    task automatic test_slice_start();
        restart_frame(16, 16, 5);
        send_block(0, 127);
        check_value("word_cnt", 32'(word_cnt), frame_bits / 32);
        check_slice_hdr(0, 5);
        check_buffer();
    endtask

    task automatic test_mb_boundaries();
        clear_buffer();
        restart_frame(32, 16, 0);
        for (int i = 0; i < 32; i++) begin
            send_block(i, 40); // short codes keep the frame inside the buffer.
        end
        check_buffer();
    endtask

    task automatic test_end_of_frame();
        logic [31:0] got;
        logic [31:0] mask;
        check_value("frame_done", 32'(frame_done), 1);
        check_value("word_cnt", 32'(word_cnt) * 32, frame_bits);
        read_word(word_cnt - 1, got);
        mask = (32'd1 << (last_pad + 1)) - 32'd1;
        check_true((got & mask) == (32'd1 << last_pad),
                   "frame does not end in a stop bit followed by zero padding");
    endtask

    task automatic test_frame_restart();
        int start;
        start = exp_cnt;
        restart_frame(16, 16, 6);
        check_value("frame_done", 32'(frame_done), 0);
        for (int i = 0; i < 16; i++) begin
            send_block(i, 16);
        end
        check_slice_hdr(start, 6);
        check_buffer();
    endtask

    task automatic test_buffer_clear();
        clear_buffer();
        check_buffer();
    endtask

    task automatic test_saturation();
        int i;
        i = 0;
        restart_frame(32, 32, 7);
        words_made = 0;
        while (words_made < 70 && i < 64) begin
            send_block(i, 127);
            i++;
        end
        check_true(words_made >= 70, "saturation test made fewer than 70 words");
        check_value("word_cnt", 32'(word_cnt), BUF_WORDS);
        check_buffer();
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        frame_reset = 1'b0;
        buf_clear   = 1'b0;
        cfg         = '0;
        blk_valid   = 1'b0;
        blk         = '0;
        rd_addr     = '0;
        rand_state  = 32'd24;
        value_errs  = 0;
        other_errs  = 0;
        cycles      = 0;
        exp_cnt     = 0;
        words_made  = 0;
        frame_bits  = 0;
        last_pad    = 0;
        repeat (5) @(posedge clk);
        #10;
        rst = 1'b0;
        clear_buffer(); // starts the buffer from all zero words.
        test_slice_start();
        test_mb_boundaries();
        test_end_of_frame();
        test_frame_restart();
        test_buffer_clear();
        test_saturation();
        $display("errors: %0d value, %0d other", value_errs, other_errs);
        if (value_errs + other_errs == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: src.f
epu_pkg.sv
blk_scan.sv
bit_packer.sv
stream_buf.sv
epu_h264_top.sv
tb_epu_h264.sv

// File: Bender.yml
package:
  name: epu_h264

sources:
  - epu_pkg.sv
  - blk_scan.sv
  - bit_packer.sv
  - stream_buf.sv
  - epu_h264_top.sv
  - target: test
    files:
      - tb_epu_h264.sv
